// File: rtl/spriteGeomPkg.sv
`default_nettype none

package spriteGeomPkg;

   // sprite and frame store shape
   localparam int spriteSize = 16;   // pixels per side
   localparam int frameCount = 4;
   localparam int frameBits  = 2;
   localparam int rowBits    = 4;
   localparam int colBits    = 4;

   // raster geometry of the small test screen
   localparam int hActive    = 64;
   localparam int hSyncStart = 68;
   localparam int hSyncEnd   = 74;   // first cycle after sync
   localparam int hTotal     = 80;
   localparam int vActive    = 48;
   localparam int vSyncStart = 49;
   localparam int vSyncEnd   = 51;   // first line after sync
   localparam int vTotal     = 52;
   localparam int hBits      = 7;
   localparam int vBits      = 6;

endpackage

`default_nettype wire

// File: rtl/spriteBusPkg.sv
`default_nettype none

package spriteBusPkg;

   localparam int wbAddrBits = 7;
   localparam int wbDataBits = 16;
   localparam int holdBits   = 8;    // width of the hold register

   // control register map
   localparam logic [wbAddrBits-1:0] regCtrl     = 7'h00;   // bit 0 enable
   localparam logic [wbAddrBits-1:0] regPosX     = 7'h01;
   localparam logic [wbAddrBits-1:0] regPosY     = 7'h02;
   localparam logic [wbAddrBits-1:0] regAnim     = 7'h03;   // first 1:0, last 3:2
   localparam logic [wbAddrBits-1:0] regHold     = 7'h04;
   localparam logic [wbAddrBits-1:0] regCurFrame = 7'h05;   // read only

   // frame rows live from here to the top of the address space
   // word offset is frame*16 + row, bit c of the word is column c
   localparam logic [wbAddrBits-1:0] frameWinBase = 7'h40;

endpackage

`default_nettype wire

// File: rtl/frameStore.sv
`timescale 1ns/1ps
`default_nettype none

module frameStore (
   input  logic                                                  clk,
   input  logic                                                  rowWe,
   input  logic [spriteGeomPkg::frameBits+spriteGeomPkg::rowBits-1:0] rowAddr,
   input  logic [spriteGeomPkg::spriteSize-1:0]                  rowData,
   input  logic                                                  rdEn,
   input  logic [spriteGeomPkg::frameBits+spriteGeomPkg::rowBits
                 +spriteGeomPkg::colBits-1:0]                    rdAddr,
   output logic                                                  rdBit
);
   import spriteGeomPkg::*;

   localparam int rowIdxBits = frameBits + rowBits;
   localparam int memRows    = frameCount * spriteSize;

   logic [spriteSize-1:0] mem [0:memRows-1];   // one word per sprite row
   logic [rowIdxBits-1:0] rdRow;
   logic [colBits-1:0]    rdCol;

   assign rdRow = rdAddr[rowIdxBits+colBits-1:colBits];   // frame and row
   assign rdCol = rdAddr[colBits-1:0];                    // pixel within the row

   // whole-row write from the bus side
   always_ff @(posedge clk) begin
      if (rowWe) begin
         mem[rowAddr] <= rowData;
      end
   end

   // one-bit read port, one cycle of latency like the block RAM it replaces
   always_ff @(posedge clk) begin
      if (rdEn) begin
         rdBit <= mem[rdRow][rdCol];
      end
   end

endmodule

`default_nettype wire

// File: rtl/rasterTiming.sv
`timescale 1ns/1ps
`default_nettype none

module rasterTiming (
   input  logic                            clk,
   input  logic                            rstN,
   output logic [spriteGeomPkg::hBits-1:0] hCount,
   output logic [spriteGeomPkg::vBits-1:0] vCount,
   output logic                            active,
   output logic                            hSyncRaw,
   output logic                            vSyncRaw,
   output logic                            frameStart
);
   import spriteGeomPkg::*;

   logic lineEnd;
   logic frameEnd;

   assign lineEnd  = (hCount == hBits'(hTotal - 1));
   assign frameEnd = (vCount == vBits'(vTotal - 1));

   // free-running pixel and line counters
   always_ff @(posedge clk) begin
      if (!rstN) begin
         hCount <= '0;
         vCount <= '0;
      end else if (lineEnd) begin
         hCount <= '0;
         if (frameEnd) begin
            vCount <= '0;
         end else begin
            vCount <= vCount + 1'b1;
         end
      end else begin
         hCount <= hCount + 1'b1;
      end
   end

   // decode straight from the counters, the renderer does the registering
   assign active = (hCount < hBits'(hActive)) && (vCount < vBits'(vActive));

   assign hSyncRaw = (hCount >= hBits'(hSyncStart)) && (hCount < hBits'(hSyncEnd));
   assign vSyncRaw = (vCount >= vBits'(vSyncStart)) && (vCount < vBits'(vSyncEnd));

   assign frameStart = (hCount == '0) && (vCount == '0);   // first pixel of a frame

endmodule

`default_nettype wire

// File: rtl/animSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module animSequencer (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic                                frameStart,
   input  logic                                enable,
   input  logic                                animLoad,
   input  logic [spriteGeomPkg::frameBits-1:0] animFirst,
   input  logic [spriteGeomPkg::frameBits-1:0] animLast,
   input  logic [spriteBusPkg::holdBits-1:0]   hold,
   output logic [spriteGeomPkg::frameBits-1:0] curFrame
);
   import spriteGeomPkg::*;
   import spriteBusPkg::*;

   logic [holdBits-1:0]   holdCount;   // video frames shown of the current image
   logic [holdBits:0]     holdNext;
   logic [holdBits-1:0]   holdEff;
   logic                  tick;
   logic                  stepNow;
   logic [frameBits-1:0]  frameNext;

   assign holdEff   = (hold == '0) ? holdBits'(1) : hold;   // zero behaves as one
   assign holdNext  = {1'b0, holdCount} + 1'b1;
   assign tick      = frameStart && enable;
   assign stepNow   = tick && (holdNext >= {1'b0, holdEff});   // >= covers a lowered hold
   assign frameNext = (curFrame == animLast) ? animFirst : curFrame + 1'b1;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         curFrame  <= '0;
         holdCount <= '0;
      end else if (animLoad) begin   // a reload beats a step in the same cycle
         curFrame  <= animFirst;
         holdCount <= '0;
      end else if (stepNow) begin
         curFrame  <= frameNext;
         holdCount <= '0;
      end else if (tick) begin
         holdCount <= holdNext[holdBits-1:0];
      end
   end

endmodule

`default_nettype wire

// File: rtl/spriteRender.sv
`timescale 1ns/1ps
`default_nettype none

module spriteRender (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic [spriteGeomPkg::hBits-1:0]     hCount,
   input  logic [spriteGeomPkg::vBits-1:0]     vCount,
   input  logic                                active,
   input  logic                                hSyncRaw,
   input  logic                                vSyncRaw,
   input  logic [spriteGeomPkg::hBits-1:0]     posX,
   input  logic [spriteGeomPkg::vBits-1:0]     posY,
   input  logic [spriteGeomPkg::frameBits-1:0] curFrame,
   input  logic                                enable,
   output logic                                rdEn,
   output logic [spriteGeomPkg::frameBits+spriteGeomPkg::rowBits
                 +spriteGeomPkg::colBits-1:0]  rdAddr,
   input  logic                                rdBit,
   output logic                                pixel,
   output logic                                de,
   output logic                                hSync,
   output logic                                vSync
);
   import spriteGeomPkg::*;

   logic [hBits:0] dx;   // one extra bit so positions left of the sprite stay large
   logic [vBits:0] dy;
   logic           insideNow;
   logic           insideQ;

   assign dx = {1'b0, hCount} - {1'b0, posX};
   assign dy = {1'b0, vCount} - {1'b0, posY};

   assign insideNow = enable && active
                      && (dx < (hBits + 1)'(spriteSize))
                      && (dy < (vBits + 1)'(spriteSize));

   // frame, row, column into the 1-bit store
   assign rdAddr = {curFrame, dy[rowBits-1:0], dx[colBits-1:0]};
   assign rdEn   = insideNow;   // idle the RAM outside the box

   // delay everything by the one cycle the RAM read takes
   always_ff @(posedge clk) begin
      if (!rstN) begin
         insideQ <= 1'b0;
         de      <= 1'b0;
         hSync   <= 1'b0;
         vSync   <= 1'b0;
      end else begin
         insideQ <= insideNow;
         de      <= active;
         hSync   <= hSyncRaw;
         vSync   <= vSyncRaw;
      end
   end

   assign pixel = insideQ && rdBit;   // stale rdBit is masked outside the sprite

endmodule

`default_nettype wire

// File: rtl/spriteRegs.sv
`timescale 1ns/1ps
`default_nettype none

module spriteRegs (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic                                wbCyc,
   input  logic                                wbStb,
   input  logic                                wbWe,
   input  logic [spriteBusPkg::wbAddrBits-1:0] wbAdr,
   input  logic [spriteBusPkg::wbDataBits-1:0] wbDatW,
   output logic                                wbAck,
   output logic [spriteBusPkg::wbDataBits-1:0] wbDatR,
   output logic                                enable,
   output logic [spriteGeomPkg::hBits-1:0]     posX,
   output logic [spriteGeomPkg::vBits-1:0]     posY,
   output logic [spriteGeomPkg::frameBits-1:0] animFirst,
   output logic [spriteGeomPkg::frameBits-1:0] animLast,
   output logic [spriteBusPkg::holdBits-1:0]   hold,
   output logic                                animLoad,
   input  logic [spriteGeomPkg::frameBits-1:0] curFrame,
   output logic                                rowWe,
   output logic [spriteGeomPkg::frameBits+spriteGeomPkg::rowBits-1:0] rowAddr,
   output logic [spriteGeomPkg::spriteSize-1:0] rowData
);
   import spriteBusPkg::*;
   import spriteGeomPkg::*;

   logic                  req;        // new access waiting for its ack
   logic                  wrReq;
   logic                  inWindow;
   logic [wbDataBits-1:0] rdMux;

   // ack drops for a cycle after each access, so req cannot fire twice in a row
   assign req      = wbCyc && wbStb && !wbAck;
   assign wrReq    = req && wbWe;
   assign inWindow = (wbAdr >= frameWinBase);

   // master holds address and data through the ack cycle
   assign rowAddr = wbAdr[frameBits+rowBits-1:0];
   assign rowData = wbDatW;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         wbAck     <= 1'b0;
         rowWe     <= 1'b0;
         animLoad  <= 1'b0;
         enable    <= 1'b0;
         posX      <= '0;
         posY      <= '0;
         animFirst <= '0;
         animLast  <= '0;
         hold      <= '0;
      end else begin
         wbAck    <= req;
         rowWe    <= wrReq && inWindow;          // lines up with the ack
         animLoad <= wrReq && (wbAdr == regAnim);
         if (wrReq) begin
            case (wbAdr)
               regCtrl: enable <= wbDatW[0];
               regPosX: posX   <= wbDatW[hBits-1:0];
               regPosY: posY   <= wbDatW[vBits-1:0];
               regAnim: begin
                  animFirst <= wbDatW[frameBits-1:0];
                  animLast  <= wbDatW[2*frameBits-1:frameBits];
               end
               regHold: hold   <= wbDatW[holdBits-1:0];
               default: ;                            // frame window and holes
            endcase
         end
      end
   end

   // readback, unused bits and the frame window read as zero
   always_comb begin
      rdMux = '0;
      case (wbAdr)
         regCtrl:     rdMux[0] = enable;
         regPosX:     rdMux[hBits-1:0] = posX;
         regPosY:     rdMux[vBits-1:0] = posY;
         regAnim:     rdMux[2*frameBits-1:0] = {animLast, animFirst};
         regHold:     rdMux[holdBits-1:0] = hold;
         regCurFrame: rdMux[frameBits-1:0] = curFrame;
         default:     rdMux = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (req) begin
         wbDatR <= rdMux;   // valid during the ack cycle
      end
   end

endmodule

`default_nettype wire

// File: rtl/spriteTop.sv
`timescale 1ns/1ps
`default_nettype none

module spriteTop (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic                                wbCyc,
   input  logic                                wbStb,
   input  logic                                wbWe,
   input  logic [spriteBusPkg::wbAddrBits-1:0] wbAdr,
   input  logic [spriteBusPkg::wbDataBits-1:0] wbDatW,
   output logic                                wbAck,
   output logic [spriteBusPkg::wbDataBits-1:0] wbDatR,
   output logic                                pixel,
   output logic                                de,
   output logic                                hSync,
   output logic                                vSync
);
   import spriteGeomPkg::*;
   import spriteBusPkg::*;

   // control registers
   logic                           enable;
   logic [hBits-1:0]               posX;
   logic [vBits-1:0]               posY;
   logic [frameBits-1:0]           animFirst;
   logic [frameBits-1:0]           animLast;
   logic [holdBits-1:0]            hold;
   logic                           animLoad;
   logic [frameBits-1:0]           curFrame;

   // frame store ports
   logic                           rowWe;
   logic [frameBits+rowBits-1:0]   rowAddr;
   logic [spriteSize-1:0]          rowData;
   logic                           rdEn;
   logic [frameBits+rowBits+colBits-1:0] rdAddr;
   logic                           rdBit;

   // raster
   logic [hBits-1:0]               hCount;
   logic [vBits-1:0]               vCount;
   logic                           active;
   logic                           hSyncRaw;
   logic                           vSyncRaw;
   logic                           frameStart;

   spriteRegs regs (
      .clk, .rstN,
      .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbAck, .wbDatR,
      .enable, .posX, .posY, .animFirst, .animLast, .hold, .animLoad,
      .curFrame,
      .rowWe, .rowAddr, .rowData
   );

   frameStore store (
      .clk, .rowWe, .rowAddr, .rowData,
      .rdEn, .rdAddr, .rdBit
   );

   rasterTiming raster (
      .clk, .rstN,
      .hCount, .vCount, .active, .hSyncRaw, .vSyncRaw, .frameStart
   );

   animSequencer seq (
      .clk, .rstN, .frameStart, .enable, .animLoad,
      .animFirst, .animLast, .hold, .curFrame
   );

   spriteRender render (
      .clk, .rstN,
      .hCount, .vCount, .active, .hSyncRaw, .vSyncRaw,
      .posX, .posY, .curFrame, .enable,
      .rdEn, .rdAddr, .rdBit,
      .pixel, .de, .hSync, .vSync
   );

endmodule

`default_nettype wire

// File: bench/spriteTb.sv
`timescale 1ns/1ps
`default_nettype none

module spriteTb;
   import spriteBusPkg::*;

   logic clk, rstN, wbCyc, wbStb, wbWe, wbAck, pixel, de, hSync, vSync;
   logic [6:0]  wbAdr;
   logic [15:0] wbDatW, wbDatR;

   logic [15:0] shadow [0:63];   // copy of every row written to the frame store
   logic        mEnable;
   logic [6:0]  mPosX;
   logic [5:0]  mPosY;
   logic [1:0]  mFirst, mLast, mFrame;
   logic [7:0]  mHold;
   int          mHoldCount, errors, testErrStart, testsRun, testsFailed;
   int          capTarget, capDone, row, col, hsLines, seed;
   logic        prevDe, prevVs, prevHs, armed, capOn, linesValid;
   string       lines[$];
   longint      budget;
   logic        budgetReady;

   spriteTop uut (.clk, .rstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbAck, .wbDatR,
                  .pixel, .de, .hSync, .vSync);

   always #20 clk = ~clk;

   // video frame step as seen at the first visible pixel
   task automatic stepAnimation();
      int holdEff;
      if (mEnable) begin
         holdEff = (mHold == 8'd0) ? 1 : int'(mHold);
         mHoldCount = mHoldCount + 1;
         if (mHoldCount >= holdEff) begin
            mHoldCount = 0;
            mFrame = (mFrame == mLast) ? mFirst : mFrame + 2'd1;
         end
      end
   endtask

   function automatic logic expectPixel(input int x, input int y);
      int dx;
      int dy;
      logic [15:0] bits;
      dx = x - int'(mPosX);
      dy = y - int'(mPosY);
      if (!mEnable || dx < 0 || dx > 15 || dy < 0 || dy > 15) return 1'b0;
      bits = shadow[int'(mFrame) * 16 + dy];
      return bits[dx];
   endfunction

   task automatic updateModel(input logic [6:0] addr, input logic [15:0] data);
      if (addr >= frameWinBase) shadow[addr - frameWinBase] = data;
      else if (addr == regCtrl) mEnable = data[0];
      else if (addr == regPosX) mPosX = data[6:0];
      else if (addr == regPosY) mPosY = data[5:0];
      else if (addr == regHold) mHold = data[7:0];
      else if (addr == regAnim) begin
         mFirst = data[1:0];
         mLast = data[3:2];
         mFrame = data[1:0];   // reload restarts the sequence
         mHoldCount = 0;
      end
   endtask

   task automatic reportBadLine(input string text);
      $display("trace line is malformed: %s", text);
      errors++;
   endtask

   task automatic busAccess(input logic we, input logic [6:0] addr, input logic [15:0] wdata,
                            output logic [15:0] rdata);
      int waitCycles;
      rdata = 16'h0;
      waitCycles = 0;
      @(posedge clk);
      wbCyc <= 1'b1;
      wbStb <= 1'b1;
      wbWe <= we;
      wbAdr <= addr;
      wbDatW <= wdata;
      do begin
         @(posedge clk);
         waitCycles++;
      end while (!wbAck && waitCycles < 20);
      if (!wbAck) begin
         $display("no ack for the access at address 0x%h", addr);
         errors++;
      end else if (waitCycles != 2) begin
         $display("ack at address 0x%h came after %0d cycles instead of 2", addr, waitCycles);
         errors++;
      end
      rdata = wbDatR;
      if (we) updateModel(addr, wdata);
      wbCyc <= 1'b0;
      wbStb <= 1'b0;
      wbWe <= 1'b0;
      @(posedge clk);
      if (wbAck) begin
         $display("ack stayed high a second cycle at address 0x%h", addr);
         errors++;
      end
   endtask

   // raster monitor that steps the model and compares captured frames
   always @(posedge clk) begin
      if (rstN) begin
         if (hSync && !prevHs) hsLines++;
         if (prevVs && !vSync) armed = 1'b1;
         if (de && vSync) begin
            $display("de is high during vertical sync");
            errors++;
         end
         if (de && !prevDe) begin
            if (armed) begin
               armed = 1'b0;
               stepAnimation();
               if (linesValid && hsLines != 52) begin
                  $display("[ERROR] hSync pulses per frame: expected %h, got %h", 52, hsLines);
                  errors++;
               end
               if (capOn) begin
                  $display("captured frame ended after only %0d rows", row + 1);
                  errors++;
               end
               linesValid = 1'b1;
               hsLines = 0;
               capOn = (capDone < capTarget);
               row = 0;
            end else begin
               row++;
            end
            col = 0;
         end
         if (de && capOn) begin
            if (pixel !== expectPixel(col, row)) begin
               $display("[ERROR] pixel at x=%0d y=%0d frame %0d: expected %h, got %h",
                        col, row, mFrame, expectPixel(col, row), pixel);
               errors++;
            end
            col++;
         end
         if (!de && prevDe && capOn) begin
            if (col != 64) begin
               $display("[ERROR] de cycles in row %0d: expected %h, got %h", row, 64, col);
               errors++;
            end
            if (row == 47) begin
               capOn = 1'b0;
               capDone++;
            end
         end
      end
      prevDe = de;
      prevVs = vSync;
      prevHs = hSync;
   end

   initial begin
      wait (budgetReady);
      #(budget * 40);
      $display("watchdog expired before the trace finished");
      $display("Test failed");
      $finish;
   end

   initial begin
      int fd;
      string line, cmd, name;
      logic [6:0] addr;
      logic [15:0] data, rdata;
      int n;
      int fields;
      clk = 1'b0;
      rstN = 1'b0;
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe = 1'b0;
      wbAdr = 7'h0;
      wbDatW = 16'h0;
      {mEnable, mPosX, mPosY, mFirst, mLast, mFrame, mHold} = '0;
      {prevDe, prevVs, prevHs, armed, capOn, linesValid, budgetReady} = '0;
      {mHoldCount, errors, testErrStart, testsRun, testsFailed} = '0;
      {capTarget, capDone, row, col, hsLines} = '0;
      seed = 32'h5810;
      budget = 200;
      fd = $fopen("bench/spriteTrace.txt", "r");
      if (fd == 0) begin
         $display("cannot open bench/spriteTrace.txt");
         $display("Test failed");
         $finish;
      end
      while (!$feof(fd)) begin
         if ($fgets(line, fd) != 0) lines.push_back(line);
      end
      $fclose(fd);
      foreach (lines[i]) begin   // watchdog budget from the trace length
         if ($sscanf(lines[i], "%s %d", cmd, n) >= 1) begin
            if (cmd == "W" || cmd == "R" || cmd == "Q") budget += 200;
            else if (cmd == "F") budget += 16 * 200;
            else if (cmd == "C") budget += (n + 2) * 4160;
         end
      end
      budgetReady = 1'b1;
      repeat (5) @(posedge clk);
      rstN <= 1'b1;
      foreach (lines[i]) begin
         if ($sscanf(lines[i], "%s", cmd) != 1 || cmd.getc(0) == "#") continue;
         if (cmd == "W") begin
            fields = $sscanf(lines[i], "%s %h %h", cmd, addr, data);
            if (fields != 3) reportBadLine(lines[i]);
            busAccess(1'b1, addr, data, rdata);
         end else if (cmd == "R") begin
            fields = $sscanf(lines[i], "%s %h %h", cmd, addr, data);
            if (fields != 3) reportBadLine(lines[i]);
            busAccess(1'b0, addr, 16'h0, rdata);
            if (rdata !== data) begin
               $display("[ERROR] wbDatR at 0x%h: expected %h, got %h", addr, data, rdata);
               errors++;
            end
         end else if (cmd == "Q") begin
            busAccess(1'b0, regCurFrame, 16'h0, rdata);
            if (rdata !== {14'h0, mFrame}) begin
               $display("[ERROR] wbDatR curFrame: expected %h, got %h", {14'h0, mFrame}, rdata);
               errors++;
            end
         end else if (cmd == "F") begin
            fields = $sscanf(lines[i], "%s %d", cmd, n);
            if (fields != 2) reportBadLine(lines[i]);
            for (int r = 0; r < 16; r++) begin
               data = $random(seed);
               busAccess(1'b1, frameWinBase + 7'(n * 16 + r), data, rdata);
            end
         end else if (cmd == "C") begin
            fields = $sscanf(lines[i], "%s %d", cmd, n);
            if (fields != 2) reportBadLine(lines[i]);
            capTarget = capDone + n;
            while (capDone < capTarget) @(posedge clk);
         end else if (cmd == "D") begin
            fields = $sscanf(lines[i], "%s %s", cmd, name);
            if (fields != 2) reportBadLine(lines[i]);
            testsRun++;
            if (errors == testErrStart) $display("test %s: passed", name);
            else begin
               $display("test %s: failed with %0d errors", name, errors - testErrStart);
               testsFailed++;
            end
            testErrStart = errors;
         end
      end
      if (errors == 0) $display("Test completed successfully");
      else $display("Test failed");
      $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
      $finish;
   end

endmodule

`default_nettype wire

// File: bench/spriteTrace.txt
# W addr data (hex) | R addr expected (hex) | F frame, random rows | Q check curFrame
# C number of video frames to capture | D test name, ends a test
F 0
F 1
F 2
F 3
W 4f 8001
W 01 0012
W 02 0008
W 03 000b
W 04 0080
W 00 0001
R 01 0012
R 02 0008
R 03 000b
R 04 0080
R 00 0001
W 01 00ff
R 01 007f
W 02 ffff
R 02 003f
R 40 0000
R 06 0000
D readback
W 03 000a
W 04 00ff
W 01 0014
W 02 000a
C 2
W 01 003a
W 02 0024
C 1
D static
W 01 0010
W 02 0010
W 04 0002
W 03 000c
C 6
Q
D anim
W 03 0009
C 4
Q
D reload
W 00 0000
Q
C 2
Q
D disable

// File: src.f
rtl/spriteGeomPkg.sv
rtl/spriteBusPkg.sv
rtl/frameStore.sv
rtl/rasterTiming.sv
rtl/animSequencer.sv
rtl/spriteRender.sv
rtl/spriteRegs.sv
rtl/spriteTop.sv
bench/spriteTb.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module spriteTb -f src.f -o simv \
   && ./obj_dir/simv > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
